// File: build.f
verilog/mem_map_pkg.sv
verilog/bus_pkg.sv
verilog/byte_lane_ram.sv
verilog/boot_loader.sv
verilog/wait_cfg.sv
verilog/bus_slave.sv
verilog/boot_ram_top.sv
testbench/tb_boot_ram.sv

// File: Bender.yml
package:
  name: boot_ram

sources:
  # packages first, the RTL depends on them.
  - verilog/mem_map_pkg.sv
  - verilog/bus_pkg.sv
  - verilog/byte_lane_ram.sv
  - verilog/boot_loader.sv
  - verilog/wait_cfg.sv
  - verilog/bus_slave.sv
  - verilog/boot_ram_top.sv
  - target: simulation
    files:
      - testbench/tb_boot_ram.sv

// File: testbench/tb_boot_ram.sv
module tb_boot_ram;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 20;

    logic                                 clk;
    logic                                 arst_n;
    bus_pkg::bus_addr_t                   address;
    logic                                 read;
    logic                                 write;
    bus_pkg::bus_word_t                   writedata;
    bus_pkg::byte_en_t                    byteenable;
    bus_pkg::bus_word_t                   readdata;
    logic                                 waitrequest;
    logic                                 inst_valid;
    logic [mem_map_pkg::word_index_w-1:0] inst_index;
    bus_pkg::bus_word_t                   instruction;
    logic                                 cfg_write;
    bus_pkg::wait_cnt_t                   cfg_wait;
    logic                                 ram_clear;

    integer seed = 32'hb766;
    int     errors = 0;
    int     checks = 0;
    int     test_errors;
    string  test_name;

    boot_ram_top u_boot_ram_top (.*);

    always #10 clk = ~clk;                             // 20 ns period.

    // ##################################################
    // compare and report
    // ##################################################

    task automatic check_word(input string what, input bus_pkg::bus_word_t exp,
                              input bus_pkg::bus_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("** Error %s: %s expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input bus_pkg::wait_cnt_t exp,
                               input bus_pkg::wait_cnt_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("** Error %s: %s expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        test_errors++;
        $display("%s: %s", test_name, what);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    // ##################################################
    // stimulus, called right after a falling edge
    // ##################################################

    task automatic bus_access(input bus_pkg::bus_addr_t addr, input logic is_write,
                              input bus_pkg::bus_word_t data, input bus_pkg::byte_en_t be,
                              output bus_pkg::bus_word_t rdata, output int stalls);
        logic accepted;
        stalls   = 0;
        accepted = 1'b0;
        address    = addr;
        read       = !is_write;
        write      = is_write;
        writedata  = data;
        byteenable = be;
        for (int c = 0; c < timeout_cycles && !accepted; c++) begin
            #1;
            accepted = !waitrequest;                   // stable until the rising edge.
            stalls   = stalls + int'(waitrequest);
            @(negedge clk);
        end
        if (!accepted) begin
            $display("%s: waitrequest never dropped within %0d cycles", test_name, timeout_cycles);
            $display("Verification failed");
            $finish;
        end else begin
            read  = 1'b0;
            write = 1'b0;
            rdata = readdata;
        end
    endtask

    task automatic load_word(input logic [mem_map_pkg::word_index_w-1:0] idx,
                             input bus_pkg::bus_word_t word);
        inst_valid  = 1'b1;
        inst_index  = idx;
        instruction = word;
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic pulse_clear();
        ram_clear = 1'b1;
        @(negedge clk);
        ram_clear = 1'b0;
    endtask

    task automatic set_wait(input bus_pkg::wait_cnt_t n);
        cfg_write = 1'b1;
        cfg_wait  = n;
        @(negedge clk);
        cfg_write = 1'b0;
    endtask

    // highest instruction byte sits at the lowest address, lane 0.
    function automatic bus_pkg::bus_word_t reverse_bytes(input bus_pkg::bus_word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // ##################################################
    // directed tests
    // ##################################################

    task automatic test_load_readback();
        logic [mem_map_pkg::word_index_w-1:0] idx [4] = '{6'd0, 6'd1, 6'd17, 6'd63};
        bus_pkg::bus_word_t                   words [4];
        bus_pkg::bus_word_t                   rdata;
        int                                   stalls;
        start_test("load_readback");
        pulse_clear();
        for (int i = 0; i < 4; i++) begin
            words[i] = $random(seed);
            load_word(idx[i], words[i]);
        end
        for (int i = 0; i < 4; i++) begin
            bus_access(mem_map_pkg::window_base + 32'(idx[i]) * 4, 1'b0, '0, '0, rdata, stalls);
            check_word("loaded word", reverse_bytes(words[i]), rdata);
        end
    endtask

    task automatic test_byte_enable();
        bus_pkg::bus_word_t old_w = $random(seed);
        bus_pkg::bus_word_t new_w = $random(seed);
        bus_pkg::bus_word_t rdata;
        int                 stalls;
        start_test("byte_enable");
        bus_access(mem_map_pkg::window_base + 8, 1'b1, old_w, 4'b1111, rdata, stalls);
        bus_access(mem_map_pkg::window_base + 8, 1'b1, new_w, 4'b0101, rdata, stalls);
        bus_access(mem_map_pkg::window_base + 8, 1'b0, '0, '0, rdata, stalls);
        check_word("merged word", {old_w[31:24], new_w[23:16], old_w[15:8], new_w[7:0]}, rdata);
    endtask

    task automatic test_wait_states();
        bus_pkg::bus_word_t rdata;
        int                 stalls;
        start_test("wait_states");
        for (int n = 0; n < 8; n++) begin
            set_wait(bus_pkg::wait_cnt_t'(n));
            check_count("wait_states register", n, u_boot_ram_top.wait_states);
            bus_access(mem_map_pkg::window_base, 1'b0, '0, '0, rdata, stalls);
            if (stalls > 7) begin
                report_problem("waitrequest stayed high for more than seven cycles");
            end else begin
                check_count("waitrequest cycles", n, bus_pkg::wait_cnt_t'(stalls));
            end
        end
        set_wait('0);
    endtask

    task automatic test_out_of_window();
        bus_pkg::bus_word_t low_w = $random(seed);
        bus_pkg::bus_word_t top_w = $random(seed);
        bus_pkg::bus_word_t rdata;
        int                 stalls;
        start_test("out_of_window");
        bus_access(mem_map_pkg::window_base, 1'b1, low_w, 4'b1111, rdata, stalls);
        bus_access(mem_map_pkg::window_base + 252, 1'b1, top_w, 4'b1111, rdata, stalls);
        bus_access(mem_map_pkg::window_base - 4, 1'b0, '0, '0, rdata, stalls);
        check_word("read below window", '0, rdata);
        bus_access(mem_map_pkg::window_base + 256, 1'b0, '0, '0, rdata, stalls);
        check_word("read above window", '0, rdata);
        bus_access(mem_map_pkg::window_base + 256, 1'b1, ~low_w, 4'b1111, rdata, stalls);
        bus_access(mem_map_pkg::window_base - 4, 1'b1, ~top_w, 4'b1111, rdata, stalls);
        bus_access(mem_map_pkg::window_base, 1'b0, '0, '0, rdata, stalls);
        check_word("first word kept", low_w, rdata);
        bus_access(mem_map_pkg::window_base + 252, 1'b0, '0, '0, rdata, stalls);
        check_word("last word kept", top_w, rdata);
    endtask

    task automatic test_clear();
        bus_pkg::bus_word_t rdata;
        int                 stalls;
        start_test("clear");
        bus_access(mem_map_pkg::window_base + 16, 1'b1, $random(seed), 4'b1111, rdata, stalls);
        bus_access(mem_map_pkg::window_base + 32, 1'b1, $random(seed), 4'b1111, rdata, stalls);
        pulse_clear();
        bus_access(mem_map_pkg::window_base + 16, 1'b0, '0, '0, rdata, stalls);
        check_word("cleared word 4", '0, rdata);
        bus_access(mem_map_pkg::window_base + 32, 1'b0, '0, '0, rdata, stalls);
        check_word("cleared word 8", '0, rdata);
    endtask

    task automatic test_load_during_write();
        bus_pkg::bus_word_t ld_w = $random(seed);
        bus_pkg::bus_word_t wr_w = $random(seed);
        bus_pkg::bus_word_t rdata;
        int                 stalls;
        start_test("load_during_write");
        fork
            load_word(6'd5, ld_w);
            bus_access(mem_map_pkg::window_base + 64, 1'b1, wr_w, 4'b1111, rdata, stalls);
        join
        if (stalls < 1) begin
            report_problem("bus write was accepted while the loader held the write port");
        end
        bus_access(mem_map_pkg::window_base + 20, 1'b0, '0, '0, rdata, stalls);
        check_word("loaded word", reverse_bytes(ld_w), rdata);
        bus_access(mem_map_pkg::window_base + 64, 1'b0, '0, '0, rdata, stalls);
        check_word("bus word", wr_w, rdata);
    endtask

    // ##################################################
    // sequence
    // ##################################################

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        address     = '0;
        read        = 1'b0;
        write       = 1'b0;
        writedata   = '0;
        byteenable  = '0;
        inst_valid  = 1'b0;
        inst_index  = '0;
        instruction = '0;
        cfg_write   = 1'b0;
        cfg_wait    = '0;
        ram_clear   = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        test_load_readback();
        $display("%-18s finished, %0d errors", test_name, test_errors);
        test_byte_enable();
        $display("%-18s finished, %0d errors", test_name, test_errors);
        test_wait_states();
        $display("%-18s finished, %0d errors", test_name, test_errors);
        test_out_of_window();
        $display("%-18s finished, %0d errors", test_name, test_errors);
        test_clear();
        $display("%-18s finished, %0d errors", test_name, test_errors);
        test_load_during_write();
        $display("%-18s finished, %0d errors", test_name, test_errors);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verilog/boot_ram_top.sv
module boot_ram_top (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  bus_pkg::bus_addr_t                   address,
    input  logic                                 read,
    input  logic                                 write,
    input  bus_pkg::bus_word_t                   writedata,
    input  bus_pkg::byte_en_t                    byteenable,
    output bus_pkg::bus_word_t                   readdata,
    output logic                                 waitrequest,
    input  logic                                 inst_valid,
    input  logic [mem_map_pkg::word_index_w-1:0] inst_index,
    input  bus_pkg::bus_word_t                   instruction,
    input  logic                                 cfg_write,
    input  bus_pkg::wait_cnt_t                   cfg_wait,
    input  logic                                 ram_clear
);

    logic                                ld_we;
    logic [mem_map_pkg::byte_addr_w-1:0] ld_addr;
    bus_pkg::bus_word_t                  ld_data;
    bus_pkg::byte_en_t                   ld_be;
    logic                                bus_we;
    logic [mem_map_pkg::byte_addr_w-1:0] bus_addr;
    bus_pkg::bus_word_t                  bus_data;
    bus_pkg::byte_en_t                   bus_be;
    logic                                rd_en;
    logic [mem_map_pkg::byte_addr_w-1:0] rd_addr;
    bus_pkg::bus_word_t                  rd_data;
    bus_pkg::wait_cnt_t                  wait_states;
    logic                                busy;

    boot_loader u_boot_loader (
        .clk         (clk),
        .arst_n      (arst_n),
        .inst_valid  (inst_valid),
        .inst_index  (inst_index),
        .instruction (instruction),
        .ld_we       (ld_we),
        .ld_addr     (ld_addr),
        .ld_data     (ld_data),
        .ld_be       (ld_be)
    );

    wait_cfg u_wait_cfg (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg_write   (cfg_write),
        .cfg_wait    (cfg_wait),
        .busy        (busy),
        .wait_states (wait_states)
    );

    bus_slave u_bus_slave (
        .clk         (clk),
        .arst_n      (arst_n),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .wait_states (wait_states),
        .ld_we       (ld_we),
        .busy        (busy),
        .bus_we      (bus_we),
        .bus_addr    (bus_addr),
        .bus_data    (bus_data),
        .bus_be      (bus_be),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    byte_lane_ram u_byte_lane_ram (
        .clk       (clk),
        .arst_n    (arst_n),
        .ram_clear (ram_clear),
        .ld_we     (ld_we),
        .ld_addr   (ld_addr),
        .ld_data   (ld_data),
        .ld_be     (ld_be),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_data  (bus_data),
        .bus_be    (bus_be),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

endmodule

// File: verilog/bus_slave.sv
module bus_slave (
    input  logic                                clk,
    input  logic                                arst_n,
    input  bus_pkg::bus_addr_t                  address,
    input  logic                                read,
    input  logic                                write,
    input  bus_pkg::bus_word_t                  writedata,
    input  bus_pkg::byte_en_t                   byteenable,
    output bus_pkg::bus_word_t                  readdata,
    output logic                                waitrequest,
    input  bus_pkg::wait_cnt_t                  wait_states,
    input  logic                                ld_we,
    output logic                                busy,
    output logic                                bus_we,
    output logic [mem_map_pkg::byte_addr_w-1:0] bus_addr,
    output bus_pkg::bus_word_t                  bus_data,
    output bus_pkg::byte_en_t                   bus_be,
    output logic                                rd_en,
    output logic [mem_map_pkg::byte_addr_w-1:0] rd_addr,
    input  bus_pkg::bus_word_t                  rd_data
);

    logic               req;
    logic               accept;
    logic               in_window;
    bus_pkg::bus_addr_t offset;
    bus_pkg::wait_cnt_t wait_cnt;
    logic               zero_q;

    // ##################################################
    // window decode
    // ##################################################

    assign offset    = address - mem_map_pkg::window_base;
    assign in_window = offset < mem_map_pkg::ram_bytes;    // below base wraps high.

    // ##################################################
    // wait states and load stall
    // ##################################################

    assign req         = read | write;
    assign busy        = req;
    assign waitrequest = req & ((wait_cnt < wait_states) | ld_we);
    assign accept      = req & ~waitrequest;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (accept || !req) begin
            wait_cnt <= '0;                            // restart for the next request.
        end else if (wait_cnt < wait_states) begin
            wait_cnt <= wait_cnt + 1'b1;               // holds at the limit during a stall.
        end
    end

    // ##################################################
    // issue to the array
    // ##################################################

    assign bus_we   = accept & write & in_window;      // out of window is dropped.
    assign bus_addr = offset[mem_map_pkg::byte_addr_w-1:0];
    assign bus_data = writedata;
    assign bus_be   = byteenable;

    assign rd_en   = accept & read & in_window;
    assign rd_addr = offset[mem_map_pkg::byte_addr_w-1:0];

    // remembers whether the last accepted read missed the window.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            zero_q <= 1'b1;
        end else if (accept && read) begin
            zero_q <= !in_window;
        end
    end

    assign readdata = zero_q ? '0 : rd_data;

    rw_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n) !(read && write)
    ) else $error("read and write requested together.");

    addr_held: assert property (
        @(posedge clk) disable iff (!arst_n) waitrequest |=> $stable(address)
    ) else $error("address changed while waitrequest was high.");

endmodule

// File: verilog/wait_cfg.sv
module wait_cfg (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cfg_write,
    input  bus_pkg::wait_cnt_t cfg_wait,
    input  logic               busy,
    output bus_pkg::wait_cnt_t wait_states
);

    logic               pend;
    bus_pkg::wait_cnt_t pend_val;

    // a write during a pending request waits until the bus is idle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_states <= '0;
            pend        <= 1'b0;
        end else if (cfg_write && !busy) begin
            wait_states <= cfg_wait;
            pend        <= 1'b0;
        end else if (cfg_write) begin
            pend <= 1'b1;                              // newest value wins.
        end else if (pend && !busy) begin
            wait_states <= pend_val;
            pend        <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_write && busy) begin
            pend_val <= cfg_wait;
        end
    end

endmodule

// File: verilog/boot_loader.sv
module boot_loader (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 inst_valid,
    input  logic [mem_map_pkg::word_index_w-1:0] inst_index,
    input  bus_pkg::bus_word_t                   instruction,
    output logic                                 ld_we,
    output logic [mem_map_pkg::byte_addr_w-1:0]  ld_addr,
    output bus_pkg::bus_word_t                   ld_data,
    output bus_pkg::byte_en_t                    ld_be
);

    localparam int lane_sel_w = $clog2(bus_pkg::lanes);

    // ##################################################
    // word index to byte address
    // ##################################################

    assign ld_we   = inst_valid;                       // one cycle, never stalled.
    assign ld_addr = {inst_index, {lane_sel_w{1'b0}}};
    assign ld_be   = '1;                               // whole word every time.

    // ##################################################
    // big-endian byte order
    // ##################################################

    // instruction[31:24] goes to lane 0, the lowest address.
    always_comb begin
        for (int i = 0; i < bus_pkg::lanes; i++) begin
            ld_data[bus_pkg::byte_w*i +: bus_pkg::byte_w] =
                instruction[bus_pkg::byte_w*(bus_pkg::lanes-1-i) +: bus_pkg::byte_w];
        end
    end

    index_known: assert property (
        @(posedge clk) disable iff (!arst_n) inst_valid |-> !$isunknown(inst_index)
    ) else $error("loader strobe with unknown word index.");

endmodule

// File: verilog/byte_lane_ram.sv
module byte_lane_ram (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                ram_clear,
    input  logic                                ld_we,
    input  logic [mem_map_pkg::byte_addr_w-1:0] ld_addr,
    input  bus_pkg::bus_word_t                  ld_data,
    input  bus_pkg::byte_en_t                   ld_be,
    input  logic                                bus_we,
    input  logic [mem_map_pkg::byte_addr_w-1:0] bus_addr,
    input  bus_pkg::bus_word_t                  bus_data,
    input  bus_pkg::byte_en_t                   bus_be,
    input  logic                                rd_en,
    input  logic [mem_map_pkg::byte_addr_w-1:0] rd_addr,
    output bus_pkg::bus_word_t                  rd_data
);

    logic [bus_pkg::byte_w-1:0]          mem [mem_map_pkg::ram_bytes];
    logic                                wr_en;
    logic [mem_map_pkg::byte_addr_w-1:0] wr_addr;
    bus_pkg::bus_word_t                  wr_data;
    bus_pkg::byte_en_t                   wr_be;
    logic [mem_map_pkg::byte_addr_w-1:0] wr_lane_addr [bus_pkg::lanes];
    logic [mem_map_pkg::byte_addr_w-1:0] rd_lane_addr [bus_pkg::lanes];

    // single write port, loader wins.
    assign wr_en   = ld_we | bus_we;
    assign wr_addr = ld_we ? ld_addr : bus_addr;
    assign wr_data = ld_we ? ld_data : bus_data;
    assign wr_be   = ld_we ? ld_be : bus_be;

    always_comb begin
        for (int i = 0; i < bus_pkg::lanes; i++) begin
            wr_lane_addr[i] = wr_addr + mem_map_pkg::byte_addr_w'(i);  // wraps inside the window.
            rd_lane_addr[i] = rd_addr + mem_map_pkg::byte_addr_w'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (ram_clear) begin
            for (int i = 0; i < mem_map_pkg::ram_bytes; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            for (int i = 0; i < bus_pkg::lanes; i++) begin
                if (wr_be[i]) begin
                    mem[wr_lane_addr[i]] <= wr_data[bus_pkg::byte_w*i +: bus_pkg::byte_w];
                end
            end
        end
    end

    // lane 3 comes from the highest address.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int i = 0; i < bus_pkg::lanes; i++) begin
                rd_data[bus_pkg::byte_w*i +: bus_pkg::byte_w] <= mem[rd_lane_addr[i]];
            end
        end
    end

    // the slave has to stall behind every load.
    wr_port_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n) !(ld_we && bus_we)
    ) else $error("loader and bus write the array in the same cycle.");

endmodule

// File: verilog/bus_pkg.sv
package bus_pkg;

    // ##################################################
    // data path widths
    // ##################################################

    localparam int word_w = 32;                        // bus data width.
    localparam int lanes = 4;                          // byte lanes per word.
    localparam int byte_w = word_w / lanes;
    localparam int wait_w = 3;                         // up to 7 wait states.

    // ##################################################
    // bus types
    // ##################################################

    typedef logic [31:0] bus_addr_t;
    typedef logic [word_w-1:0] bus_word_t;
    typedef logic [lanes-1:0] byte_en_t;
    typedef logic [wait_w-1:0] wait_cnt_t;

endpackage

// File: verilog/mem_map_pkg.sv
package mem_map_pkg;

    // ##################################################
    // boot window in the processor address map
    // ##################################################

    // first bus address of the RAM, the MIPS reset vector.
    localparam logic [31:0] window_base = 32'hBFC00000;

    localparam int ram_bytes = 256;                    // size of the array.

    // ##################################################
    // address widths inside the window
    // ##################################################

    localparam int byte_addr_w = $clog2(ram_bytes);    // byte address.
    localparam int word_index_w = byte_addr_w - 2;     // word index, four bytes per word.

endpackage
